//--- rtl/uart_console_pkg.sv
// UART console shared types
`default_nettype none

package uart_console_pkg;

	// ******************************
	// Serial timing
	// ******************************

	// Clock cycles per serial bit
	localparam int SAMPLE_RATE = 4;
	localparam int HALF_BIT = SAMPLE_RATE / 2;

	// Consecutive low samples before the line counts as low
	localparam int FILTER_LEN = 3;

	// Width of the receiver bit-period counter
	localparam int SAMPLE_CNT_W = $clog2(SAMPLE_RATE);

	// The low-run filter has already used part of the start bit when it reports the edge,
	// so mid-bit comes sooner than HALF_BIT after detection
	localparam int START_WAIT = HALF_BIT - (FILTER_LEN - 1) / 2;

	// Console control bytes
	localparam logic [7:0] CHAR_EOT = 8'h04;
	localparam logic [7:0] CHAR_CR = 8'h0D;

	// ******************************
	// Types
	// ******************************

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_e;

	typedef enum logic [1:0] {OP_PRINT, OP_DROP, OP_FINISH} console_op_e;

	// One received 8N1 frame
	typedef struct packed {
		logic [7:0] data;
		logic       stop_ok;
	} rx_frame_t;

	// Decoded console character
	typedef struct packed {
		console_op_e op;
		logic [7:0]  data;
	} console_char_t;

endpackage

`default_nettype wire

//--- rtl/rx_line_filter.sv
// Serial line synchronizer and filter
`timescale 1ns/1ps
`default_nettype none

module rx_line_filter import uart_console_pkg::*; (
	input  logic rvx_signal_6,
	input  logic rst_n,
	input  logic uart_rx,
	output logic line_low
);

	// Two flops against metastability
	logic [1:0] sync_q;

	// Previous synchronized samples, newest in bit 0
	logic [FILTER_LEN-2:0] hist_q;

	logic all_low;

	// Newest sample and the whole history must be low
	assign all_low = ~|{hist_q, sync_q[1]};

	// ******************************
	// Sync and low-run history
	// ******************************

	always_ff @(posedge rvx_signal_6 or negedge rst_n) begin
		if (!rst_n) begin
			// Idle line is high
			sync_q   <= 2'b11;
			hist_q   <= '1;
			line_low <= 1'b0;
		end else begin
			sync_q    <= {sync_q[0], uart_rx};
			hist_q[0] <= sync_q[1];
			for (int i = 1; i < FILTER_LEN - 1; i++) begin
				hist_q[i] <= hist_q[i-1];
			end
			// Rises after a full low run, falls on the first high sample
			line_low  <= all_low;
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_rx_fsm.sv
// 8N1 oversampling frame receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fsm import uart_console_pkg::*; (
	input  logic      rvx_signal_6,
	input  logic      rst_n,
	input  logic      line_low,
	output rx_frame_t frame,
	output logic      frame_valid
);

	rx_state_e               state_q;
	logic [SAMPLE_CNT_W-1:0] cnt_q;
	logic [2:0]              bit_idx_q;
	logic [7:0]              shift_q;
	logic                    line_low_q;
	logic                    start_edge;
	logic                    sample_now;

	// Line going low after idle or a stop bit
	assign start_edge = line_low & ~line_low_q;

	// Counter runs down to the next sample point
	assign sample_now = (cnt_q == '0);

	// ******************************
	// Frame state machine
	// ******************************

	always_ff @(posedge rvx_signal_6 or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= IDLE;
			cnt_q       <= '0;
			bit_idx_q   <= '0;
			line_low_q  <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			line_low_q  <= line_low;
			frame_valid <= 1'b0;
			case (state_q)
			IDLE: begin
				if (start_edge) begin
					state_q <= START;
					cnt_q   <= SAMPLE_CNT_W'(START_WAIT - 1);
				end
			end
			START: begin
				if (sample_now) begin
					// Start bit must still be low at mid-bit
					if (line_low) begin
						state_q   <= DATA;
						cnt_q     <= SAMPLE_CNT_W'(SAMPLE_RATE - 1);
						bit_idx_q <= '0;
					end else begin
						state_q <= IDLE;
					end
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end
			DATA: begin
				if (sample_now) begin
					cnt_q     <= SAMPLE_CNT_W'(SAMPLE_RATE - 1);
					bit_idx_q <= bit_idx_q + 3'd1;
					if (bit_idx_q == 3'd7) begin
						state_q <= STOP;
					end
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end
			STOP: begin
				if (sample_now) begin
					frame_valid <= 1'b1;
					state_q     <= IDLE;
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end
			default: begin
				state_q <= IDLE;
			end
			endcase
		end
	end

	// ******************************
	// Data path
	// ******************************

	always_ff @(posedge rvx_signal_6) begin
		// LSB first, so shift in from the top
		if (state_q == DATA && sample_now) begin
			shift_q <= {~line_low, shift_q[7:1]};
		end
		if (state_q == STOP && sample_now) begin
			frame.data    <= shift_q;
			frame.stop_ok <= ~line_low;
		end
	end

endmodule

`default_nettype wire

//--- rtl/console_decoder.sv
// Console character decoder
`timescale 1ns/1ps
`default_nettype none

module console_decoder import uart_console_pkg::*; (
	input  logic          rvx_signal_6,
	input  logic          rst_n,
	input  rx_frame_t     frame,
	input  logic          frame_valid,
	output console_char_t char_out,
	output logic          char_valid,
	output logic          core_finish,
	output logic [7:0]    frame_err_count
);

	console_op_e op;
	logic        accept;

	// Map the received byte to a console operation
	always_comb begin
		case (frame.data)
		CHAR_EOT: op = OP_FINISH;
		CHAR_CR:  op = OP_DROP;
		default:  op = OP_PRINT;
		endcase
	end

	// Nothing gets through once finished
	assign accept = frame_valid & ~core_finish;

	// ******************************
	// Status and strobe
	// ******************************

	always_ff @(posedge rvx_signal_6 or negedge rst_n) begin
		if (!rst_n) begin
			char_valid      <= 1'b0;
			core_finish     <= 1'b0;
			frame_err_count <= '0;
		end else begin
			char_valid <= 1'b0;
			if (accept) begin
				if (!frame.stop_ok) begin
					// Saturating error count
					if (frame_err_count != 8'hff) begin
						frame_err_count <= frame_err_count + 8'd1;
					end
				end else begin
					char_valid <= (op == OP_PRINT);
					if (op == OP_FINISH) begin
						core_finish <= 1'b1;
					end
				end
			end
		end
	end

	// Character payload for good frames
	always_ff @(posedge rvx_signal_6) begin
		if (accept && frame.stop_ok) begin
			char_out <= '{op: op, data: frame.data};
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_console_top.sv
// UART console monitor top
`timescale 1ns/1ps
`default_nettype none

module uart_console_top import uart_console_pkg::*; (
	input  logic          rvx_signal_6,
	input  logic          rst_n,
	input  logic          uart_rx,
	output console_char_t char_out,
	output logic          char_valid,
	output logic          core_finish,
	output logic [7:0]    frame_err_count
);

	logic      line_low;
	rx_frame_t frame;
	logic      frame_valid;

	// ******************************
	// Line filter
	// ******************************

	rx_line_filter u_filter (
		.rvx_signal_6 (rvx_signal_6),
		.rst_n        (rst_n),
		.uart_rx      (uart_rx),
		.line_low     (line_low)
	);

	// ******************************
	// Frame receiver
	// ******************************

	uart_rx_fsm u_rx (
		.rvx_signal_6 (rvx_signal_6),
		.rst_n        (rst_n),
		.line_low     (line_low),
		.frame        (frame),
		.frame_valid  (frame_valid)
	);

	// Byte to console operation
	console_decoder u_decoder (
		.rvx_signal_6    (rvx_signal_6),
		.rst_n           (rst_n),
		.frame           (frame),
		.frame_valid     (frame_valid),
		.char_out        (char_out),
		.char_valid      (char_valid),
		.core_finish     (core_finish),
		.frame_err_count (frame_err_count)
	);

endmodule

`default_nettype wire

//--- verif/uart_console_assert.sv
// Console output assertions
`timescale 1ns/1ps
`default_nettype none

module uart_console_assert import uart_console_pkg::*; (
	input logic          rvx_signal_6,
	input logic          rst_n,
	input console_char_t char_out,
	input logic          char_valid,
	input logic          core_finish
);

	// Character strobe lasts one cycle
	strobe_width: assert property (@(posedge rvx_signal_6) disable iff (!rst_n)
		char_valid |=> !char_valid)
		else $error("char_valid high in two consecutive cycles");

	// Finish flag holds until reset
	finish_sticky: assert property (@(posedge rvx_signal_6) disable iff (!rst_n)
		core_finish |=> core_finish)
		else $error("core_finish fell while out of reset");

	print_only: assert property (@(posedge rvx_signal_6) disable iff (!rst_n)
		char_valid |-> char_out.op == OP_PRINT)
		else $error("char_valid with an opcode other than OP_PRINT");

endmodule

bind uart_console_top uart_console_assert u_assert (.*);

`default_nettype wire

//--- verif/tb_uart_console.sv
// UART console monitor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_uart_console import uart_console_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20 * SAMPLE_RATE;

	typedef enum logic [1:0] {EV_PRINT, EV_ERR, EV_FINISH} event_kind_e;

	// One observable DUT response
	// Data is the byte for a print and the new error count for an error
	typedef struct packed {
		event_kind_e kind;
		logic [7:0]  data;
	} exp_event_t;

	logic          rvx_signal_6;
	logic          rst_n;
	logic          uart_rx;
	console_char_t char_out;
	logic          char_valid;
	logic          core_finish;
	logic [7:0]    frame_err_count;

	exp_event_t exp_q[$];
	logic       model_finish;
	logic [7:0] model_err;
	logic [7:0] err_seen;
	logic       finish_seen;
	logic       valid_prev;

	uart_console_top UUT (
		.rvx_signal_6    (rvx_signal_6),
		.rst_n           (rst_n),
		.uart_rx         (uart_rx),
		.char_out        (char_out),
		.char_valid      (char_valid),
		.core_finish     (core_finish),
		.frame_err_count (frame_err_count)
	);

	always #20 rvx_signal_6 = ~rvx_signal_6;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("mismatch at %0t: %s expected %0h actual %0h",
				$time, name, expected, actual));
		end
	endtask

	task automatic take_event(input string what, output exp_event_t ev);
		if (exp_q.size() == 0) begin
			fail_run($sformatf("unexpected %s at %0t with no frame pending", what, $time));
		end else begin
			ev = exp_q.pop_front();
		end
	endtask

	// ******************************
	// Line driver and reference model
	// ******************************

	// Hold the line for a number of clock cycles
	task automatic drive_line(input logic value, input int cycles);
		uart_rx = value;
		repeat (cycles) begin
			@(posedge rvx_signal_6);
			#1;
		end
	endtask

	// 8N1, LSB first
	task automatic send_frame(input logic [7:0] value, input logic stop);
		drive_line(1'b0, SAMPLE_RATE);
		for (int i = 0; i < 8; i++) begin
			drive_line(value[i], SAMPLE_RATE);
		end
		drive_line(stop, SAMPLE_RATE);
	endtask

	task automatic expect_frame(input logic [7:0] value, input logic stop);
		if (!model_finish) begin
			if (!stop) begin
				// Saturated counter shows no change
				if (model_err != 8'hff) begin
					model_err = model_err + 8'd1;
					exp_q.push_back('{kind: EV_ERR, data: model_err});
				end
			end else if (value == CHAR_EOT) begin
				model_finish = 1'b1;
				exp_q.push_back('{kind: EV_FINISH, data: value});
			end else if (value != CHAR_CR) begin
				exp_q.push_back('{kind: EV_PRINT, data: value});
			end
		end
	endtask

	// ******************************
	// Output monitor
	// ******************************

	always @(negedge rvx_signal_6) begin : watch_outputs
		exp_event_t ev;
		if (rst_n) begin
			if (char_valid && valid_prev) begin
				fail_run("char_valid stayed high for two cycles");
			end
			if (finish_seen && !core_finish) begin
				fail_run("core_finish fell while out of reset");
			end
			if (char_valid) begin
				take_event("char_valid", ev);
				check_value("event kind at char_valid", EV_PRINT, ev.kind);
				check_value("char_out.op", OP_PRINT, char_out.op);
				check_value("char_out.data", ev.data, char_out.data);
			end
			if (frame_err_count != err_seen) begin
				take_event("frame_err_count change", ev);
				check_value("event kind at frame_err_count", EV_ERR, ev.kind);
				check_value("frame_err_count", ev.data, frame_err_count);
				err_seen = frame_err_count;
			end
			if (core_finish && !finish_seen) begin
				take_event("core_finish rise", ev);
				check_value("event kind at core_finish", EV_FINISH, ev.kind);
				finish_seen = 1'b1;
			end
			valid_prev = char_valid;
		end
	end

	initial begin
		int         fd;
		int         gap;
		int         wait_cnt;
		string      line;
		byte        kind;
		logic [7:0] value;
		logic       stop;

		void'($urandom(32'hf53f));
		rvx_signal_6 = 1'b0;
		rst_n        = 1'b0;
		uart_rx      = 1'b1;
		model_finish = 1'b0;
		model_err    = 8'd0;
		err_seen     = 8'd0;
		finish_seen  = 1'b0;
		valid_prev   = 1'b0;
		repeat (10) @(posedge rvx_signal_6);
		#1;
		rst_n = 1'b1;
		drive_line(1'b1, 2);
		check_value("char_valid", 0, char_valid);
		check_value("core_finish", 0, core_finish);
		check_value("frame_err_count", 0, frame_err_count);

		fd = $fopen("verif/console_input.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open verif/console_input.txt");
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 4 && line.getc(0) != "#") begin
				void'($sscanf(line, "%c %h %h", kind, value, stop));
				if (kind == "G") begin
					drive_line(1'b0, 1);
					gap = 1;
				end else if (kind == "B" || kind == "Z") begin
					expect_frame(value, stop);
					send_frame(value, stop);
					gap = (kind == "Z") ? 0 : $urandom_range(0, 3);
					// A low stop bit needs idle before the next start edge
					if (!stop && gap == 0) begin
						gap = 1;
					end
				end else begin
					fail_run($sformatf("unknown event kind %c in input file", kind));
				end
				drive_line(1'b1, gap * SAMPLE_RATE);
			end
		end
		$fclose(fd);

		wait_cnt = 0;
		while (exp_q.size() != 0) begin
			@(posedge rvx_signal_6);
			wait_cnt++;
			if (wait_cnt > TIMEOUT_CYCLES) begin
				fail_run("timeout waiting for the DUT to answer the last frames");
			end
		end
		// Late output from ignored frames would show up here
		repeat (TIMEOUT_CYCLES) @(posedge rvx_signal_6);
		@(negedge rvx_signal_6);
		check_value("core_finish", model_finish, core_finish);
		check_value("frame_err_count", model_err, frame_err_count);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
rtl/uart_console_pkg.sv
rtl/rx_line_filter.sv
rtl/uart_rx_fsm.sv
rtl/console_decoder.sv
rtl/uart_console_top.sv
verif/uart_console_assert.sv
verif/tb_uart_console.sv

//--- verif/console_input.txt
# Columns are kind, byte value in hex, stop bit
# Kind B sends a frame, Z sends one with no idle after it, G is a one-cycle low glitch
B 41 1
B 0D 1
B 7A 0
G 00 1
B 55 1
Z 48 1
Z 69 1
Z 21 1
B 00 1
B 0D 0
B FF 1
G 00 1
B 33 1
B 04 1
B 42 1
B 13 0
Z 0D 1
B 04 1
